// ==== hdl/rename_settings.svh ====
/*
 * Rename stage sizes: register counts, bundle width and operation word width
 */
`ifndef RENAME_SETTINGS_SVH
`define RENAME_SETTINGS_SVH

// Architectural register file
`define RN_ARCH_W    5
`define RN_ARCH_REGS 32

// Physical register number width
`define RN_PREG_W    6

// Instructions per bundle
`define RN_SLOTS     2

// Operation word shared by the arithmetic and memory views
`define RN_OP_W      13

`endif

// ==== hdl/rename_pkg.sv ====
/*
 * Rename stage types: register numbers, the two-view operation word,
 * incoming slots, decode classes, renamed packets and retire writes
 */
`default_nettype none
`include "rename_settings.svh"

package rename_pkg;

    typedef logic [`RN_ARCH_W-1:0] arch_reg_t;
    typedef logic [`RN_PREG_W-1:0] preg_t;

    typedef struct packed {
        logic [5:0] alu_type;
        logic [6:0] alu_opcode;
    } alu_op_t;

    // ios_type[3] marks a store
    typedef struct packed {
        logic [`RN_OP_W-10:0] pad;
        logic [5:0]           ios_type;
        logic [2:0]           ios_opcode;
    } mem_op_t;

    // The slot's port bit picks the view
    typedef union packed {
        alu_op_t alu;
        mem_op_t mem;
    } op_word_u;

    typedef struct packed {
        logic      valid;
        logic      port;
        logic      has_dest;
        arch_reg_t rs1;
        arch_reg_t rs2;
        arch_reg_t dest;
        op_word_u  op;
    } slot_in_t;

    typedef slot_in_t [`RN_SLOTS-1:0] bundle_t;

    typedef struct packed {
        logic      valid;
        logic      alloc;
        logic      is_store;
        arch_reg_t rs1;
        arch_reg_t rs2;
        arch_reg_t dest;
    } slot_class_t;

    typedef struct packed {
        logic     valid;
        logic     port;
        logic     alloc;
        logic     is_store;
        preg_t    src1;
        preg_t    src2;
        preg_t    dest;
        preg_t    old_dest;
        op_word_u op;
    } renamed_t;

    typedef struct packed {
        logic      valid;
        arch_reg_t arch;
        preg_t     preg;
    } commit_t;

endpackage

`default_nettype wire

// ==== hdl/rename_skid.sv ====
/*
 * Rename input skid buffer: registers incoming bundles and holds one
 * extra bundle while the head is stalled
 */
`timescale 1ns/1ns
`default_nettype none
`include "rename_settings.svh"

module rename_skid (
    input  wire logic                clk_i,
    input  wire logic                rst_n_i,
    input  wire logic                recovery_i,
    input  wire logic                valid_i,
    input  wire rename_pkg::bundle_t bundle_i,
    output logic                     busy_o,
    input  wire logic                pop_i,
    output logic                     head_valid_o,
    output rename_pkg::bundle_t      head_o
);
    import rename_pkg::*;

    logic    head_v_q;
    bundle_t head_q;
    logic    skid_v_q;
    bundle_t skid_q;
    logic    push;
    logic    head_free;

    // Busy only depends on the spare register, so no path from the consumer
    assign busy_o = skid_v_q;
    assign push = valid_i && !skid_v_q;
    assign head_free = !head_v_q || pop_i;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i || recovery_i) begin
            head_v_q <= 1'b0;
            skid_v_q <= 1'b0;
        end else if (head_free) begin
            // Older bundle in the spare register goes first
            if (skid_v_q) begin
                head_v_q <= 1'b1;
                skid_v_q <= 1'b0;
            end else begin
                head_v_q <= push;
            end
        end else if (push) begin
            skid_v_q <= 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (head_free) begin
            head_q <= skid_v_q ? skid_q : bundle_i;
        end else if (push) begin
            skid_q <= bundle_i;
        end
    end

    assign head_valid_o = head_v_q;
    assign head_o = head_q;

endmodule

`default_nettype wire

// ==== hdl/rename_decode.sv ====
/*
 * Rename slot decode: marks allocating slots and stores, ignores writes to x0
 */
`timescale 1ns/1ns
`default_nettype none
`include "rename_settings.svh"

module rename_decode (
    input  wire logic                                 head_valid_i,
    input  wire rename_pkg::bundle_t                  head_i,
    output rename_pkg::slot_class_t [`RN_SLOTS-1:0]   class_o
);
    import rename_pkg::*;

    always_comb begin
        for (int s = 0; s < `RN_SLOTS; s++) begin
            // A slot only counts while the head itself is valid
            class_o[s].valid = head_valid_i && head_i[s].valid;
            class_o[s].alloc = class_o[s].valid && head_i[s].has_dest
                               && (head_i[s].dest != '0);
            // Memory view is meaningful on the memory port only
            if (head_i[s].port) begin
                class_o[s].is_store = head_i[s].op.mem.ios_type[3];
            end else begin
                class_o[s].is_store = 1'b0;
            end
            class_o[s].rs1 = head_i[s].rs1;
            class_o[s].rs2 = head_i[s].rs2;
            class_o[s].dest = head_i[s].dest;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/rename_map_table.sv ====
/*
 * Register alias tables: speculative map with in-bundle bypass, committed
 * map fed by retire, and restore of the speculative map on recovery
 */
`timescale 1ns/1ns
`default_nettype none
`include "rename_settings.svh"

module rename_map_table (
    input  wire logic                                   clk_i,
    input  wire logic                                   rst_n_i,
    input  wire logic                                   recovery_i,
    input  wire rename_pkg::bundle_t                    head_i,
    input  wire rename_pkg::slot_class_t [`RN_SLOTS-1:0] class_i,
    input  wire rename_pkg::preg_t [`RN_SLOTS-1:0]      new_preg_i,
    input  wire logic                                   write_i,
    input  wire rename_pkg::commit_t [`RN_SLOTS-1:0]    commit_i,
    output rename_pkg::renamed_t [`RN_SLOTS-1:0]        map_o
);
    import rename_pkg::*;

    preg_t spec_q [`RN_ARCH_REGS];
    preg_t cmt_q [`RN_ARCH_REGS];
    preg_t cmt_next [`RN_ARCH_REGS];
    logic  same_dest;

    // Retire writes in slot order, so slot 1 wins on a shared register
    always_comb begin
        cmt_next = cmt_q;
        for (int s = 0; s < `RN_SLOTS; s++) begin
            if (commit_i[s].valid) begin
                cmt_next[commit_i[s].arch] = commit_i[s].preg;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < `RN_ARCH_REGS; i++) begin
                spec_q[i] <= preg_t'(i);
                cmt_q[i] <= preg_t'(i);
            end
        end else begin
            cmt_q <= cmt_next;
            // Restore includes this edge's retire writes
            if (recovery_i) begin
                spec_q <= cmt_next;
            end else if (write_i) begin
                for (int s = 0; s < `RN_SLOTS; s++) begin
                    if (class_i[s].alloc) begin
                        spec_q[class_i[s].dest] <= new_preg_i[s];
                    end
                end
            end
        end
    end

    assign same_dest = class_i[0].alloc && class_i[1].alloc
                       && (class_i[0].dest == class_i[1].dest);

    // Status fields are left for the result stage to fill
    always_comb begin
        map_o = '0;
        for (int s = 0; s < `RN_SLOTS; s++) begin
            map_o[s].port = head_i[s].port;
            map_o[s].op = head_i[s].op;
            map_o[s].src1 = (class_i[s].rs1 == '0) ? '0 : spec_q[class_i[s].rs1];
            map_o[s].src2 = (class_i[s].rs2 == '0) ? '0 : spec_q[class_i[s].rs2];
            map_o[s].dest = class_i[s].alloc ? new_preg_i[s] : '0;
            map_o[s].old_dest = spec_q[class_i[s].dest];
        end
        // Slot 1 sees slot 0's rename before the table does
        if (class_i[0].alloc && (class_i[1].rs1 == class_i[0].dest)) begin
            map_o[1].src1 = new_preg_i[0];
        end
        if (class_i[0].alloc && (class_i[1].rs2 == class_i[0].dest)) begin
            map_o[1].src2 = new_preg_i[0];
        end
        if (same_dest) begin
            map_o[1].old_dest = new_preg_i[0];
        end
    end

endmodule

`default_nettype wire

// ==== hdl/rename_result.sv ====
/*
 * Rename result stage: decides when a bundle moves on, pops the free list
 * and holds the renamed packets until the consumer takes them
 */
`timescale 1ns/1ns
`default_nettype none
`include "rename_settings.svh"

module rename_result (
    input  wire logic                                   clk_i,
    input  wire logic                                   rst_n_i,
    input  wire logic                                   recovery_i,
    input  wire logic                                   head_valid_i,
    input  wire rename_pkg::slot_class_t [`RN_SLOTS-1:0] class_i,
    input  wire rename_pkg::renamed_t [`RN_SLOTS-1:0]   map_i,
    input  wire rename_pkg::preg_t [`RN_SLOTS-1:0]      fl_preg_i,
    input  wire logic [`RN_SLOTS-1:0]                   fl_empty_i,
    output logic [`RN_SLOTS-1:0]                        fl_pop_o,
    output rename_pkg::preg_t [`RN_SLOTS-1:0]           new_preg_o,
    output logic                                        advance_o,
    output logic                                        out_valid_o,
    output rename_pkg::renamed_t [`RN_SLOTS-1:0]        out_pkt_o,
    input  wire logic                                   out_ready_i
);
    import rename_pkg::*;

    logic                       out_v_q;
    renamed_t [`RN_SLOTS-1:0]   pkt_q;
    renamed_t [`RN_SLOTS-1:0]   pkt_d;
    logic [`RN_SLOTS-1:0]       alloc;
    logic                       starved;
    logic                       out_free;

    // The free list offers its heads every cycle
    assign new_preg_o = fl_preg_i;

    always_comb begin
        for (int s = 0; s < `RN_SLOTS; s++) begin
            alloc[s] = class_i[s].alloc;
        end
    end

    assign starved = |(alloc & fl_empty_i);
    assign out_free = !out_v_q || out_ready_i;
    // A bundle being flushed must not consume free registers
    assign advance_o = head_valid_i && out_free && !starved && !recovery_i;
    assign fl_pop_o = alloc & {`RN_SLOTS{advance_o}};

    always_comb begin
        for (int s = 0; s < `RN_SLOTS; s++) begin
            pkt_d[s] = map_i[s];
            pkt_d[s].valid = class_i[s].valid;
            pkt_d[s].alloc = class_i[s].alloc;
            pkt_d[s].is_store = class_i[s].is_store;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i || recovery_i) begin
            out_v_q <= 1'b0;
        end else if (advance_o) begin
            out_v_q <= 1'b1;
        end else if (out_ready_i) begin
            out_v_q <= 1'b0;
        end
    end

    // Payload only changes on advance, so it stays put while stalled
    always_ff @(posedge clk_i) begin
        if (advance_o) begin
            pkt_q <= pkt_d;
        end
    end

    assign out_valid_o = out_v_q;
    assign out_pkt_o = pkt_q;

endmodule

`default_nettype wire

// ==== hdl/rename_top.sv ====
/*
 * Two-wide rename stage: skid buffer, slot decode, map tables and result
 */
`timescale 1ns/1ns
`default_nettype none
`include "rename_settings.svh"

module rename_top (
    input  wire logic                                clk_i,
    input  wire logic                                rst_n_i,
    input  wire logic                                recovery_i,
    input  wire logic                                valid_i,
    input  wire rename_pkg::bundle_t                 bundle_i,
    output logic                                     busy_o,
    input  wire rename_pkg::preg_t [`RN_SLOTS-1:0]   fl_preg_i,
    input  wire logic [`RN_SLOTS-1:0]                fl_empty_i,
    output logic [`RN_SLOTS-1:0]                     fl_pop_o,
    input  wire rename_pkg::commit_t [`RN_SLOTS-1:0] commit_i,
    output logic                                     out_valid_o,
    output rename_pkg::renamed_t [`RN_SLOTS-1:0]     out_pkt_o,
    input  wire logic                                out_ready_i
);
    import rename_pkg::*;

    logic                        head_valid;
    bundle_t                     head_bundle;
    slot_class_t [`RN_SLOTS-1:0] slot_class;
    renamed_t [`RN_SLOTS-1:0]    map_pkt;
    preg_t [`RN_SLOTS-1:0]       new_preg;
    logic                        advance;

    rename_skid u_skid (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .recovery_i   (recovery_i),
        .valid_i      (valid_i),
        .bundle_i     (bundle_i),
        .busy_o       (busy_o),
        .pop_i        (advance),
        .head_valid_o (head_valid),
        .head_o       (head_bundle)
    );

    rename_decode u_decode (
        .head_valid_i (head_valid),
        .head_i       (head_bundle),
        .class_o      (slot_class)
    );

    // Speculative writes follow the same advance that pops the skid
    rename_map_table u_map_table (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .recovery_i  (recovery_i),
        .head_i      (head_bundle),
        .class_i     (slot_class),
        .new_preg_i  (new_preg),
        .write_i     (advance),
        .commit_i    (commit_i),
        .map_o       (map_pkt)
    );

    rename_result u_result (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .recovery_i   (recovery_i),
        .head_valid_i (head_valid),
        .class_i      (slot_class),
        .map_i        (map_pkt),
        .fl_preg_i    (fl_preg_i),
        .fl_empty_i   (fl_empty_i),
        .fl_pop_o     (fl_pop_o),
        .new_preg_o   (new_preg),
        .advance_o    (advance),
        .out_valid_o  (out_valid_o),
        .out_pkt_o    (out_pkt_o),
        .out_ready_i  (out_ready_i)
    );

endmodule

`default_nettype wire

// ==== bench/tb_rename.sv ====
/*
 * Rename stage testbench: random bundles, commits and recoveries checked
 * every cycle against a model of the map tables, skid and output register
 */
`timescale 1ns/1ns
`default_nettype none
`include "rename_settings.svh"

module tb_rename;
    import rename_pkg::*;

    typedef preg_t [`RN_SLOTS-1:0]    preg_pair_t;
    typedef commit_t [`RN_SLOTS-1:0]  commit_pair_t;
    typedef renamed_t [`RN_SLOTS-1:0] pkt_pair_t;

    localparam int NUM_BUNDLES = 400;
    // Up to three cycles per bundle under back-pressure
    localparam int CYCLE_LIMIT = NUM_BUNDLES * 3;
    // Commits and recovery stay idle this long after reset
    localparam int WARMUP = 60;

    logic         clk;
    logic         rst_n;
    logic         recovery;
    logic         valid_in;
    bundle_t      bundle_in;
    logic         busy;
    preg_pair_t   fl_preg;
    logic [1:0]   fl_empty;
    logic [1:0]   fl_pop;
    commit_pair_t commit;
    logic         out_valid;
    pkt_pair_t    out_pkt;
    logic         out_ready;

    integer seed = 39;
    int     cycles = 0;
    int     errors = 0;
    int     checks = 0;
    int     accepted = 0;
    int     delivered = 0;

    // Model state
    bundle_t   skid_m [$];
    preg_t     spec_m [`RN_ARCH_REGS];
    preg_t     cmt_m [`RN_ARCH_REGS];
    logic      out_v_m;
    pkt_pair_t pkt_m;

    rename_top DUT (
        .clk_i       (clk),
        .rst_n_i     (rst_n),
        .recovery_i  (recovery),
        .valid_i     (valid_in),
        .bundle_i    (bundle_in),
        .busy_o      (busy),
        .fl_preg_i   (fl_preg),
        .fl_empty_i  (fl_empty),
        .fl_pop_o    (fl_pop),
        .commit_i    (commit),
        .out_valid_o (out_valid),
        .out_pkt_o   (out_pkt),
        .out_ready_i (out_ready)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic int rnd_below(int n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic logic slot_allocates(slot_in_t s);
        return s.valid && s.has_dest && (s.dest != 0);
    endfunction

    function automatic preg_t read_src(arch_reg_t r);
        return (r == 0) ? preg_t'(0) : spec_m[r];
    endfunction

    task automatic compare_word(input string name, input logic [63:0] exp,
                                input logic [63:0] act);
        checks++;
        assert (act === exp) else begin
            errors++;
            $display("ERR %s expected %h actual %h", name, exp, act);
        end
    endtask

    // Renames one bundle in program order and updates the speculative model
    task automatic rename_head(input bundle_t b, input preg_pair_t fresh,
                               output pkt_pair_t pkt);
        logic [1:0] alloc;
        for (int s = 0; s < `RN_SLOTS; s++) begin
            alloc[s] = slot_allocates(b[s]);
            pkt[s].valid = b[s].valid;
            pkt[s].port = b[s].port;
            pkt[s].op = b[s].op;
            pkt[s].alloc = alloc[s];
            pkt[s].is_store = b[s].port && b[s].op.mem.ios_type[3];
            pkt[s].src1 = read_src(b[s].rs1);
            pkt[s].src2 = read_src(b[s].rs2);
            pkt[s].dest = alloc[s] ? fresh[s] : preg_t'(0);
            pkt[s].old_dest = spec_m[b[s].dest];
        end
        if (alloc[0] && b[1].rs1 == b[0].dest) pkt[1].src1 = fresh[0];
        if (alloc[0] && b[1].rs2 == b[0].dest) pkt[1].src2 = fresh[0];
        if (alloc[0] && alloc[1] && b[1].dest == b[0].dest) pkt[1].old_dest = fresh[0];
        for (int s = 0; s < `RN_SLOTS; s++) begin
            if (alloc[s]) spec_m[b[s].dest] = fresh[s];
        end
    endtask

    task automatic drive_random();
        bundle_t b;
        for (int s = 0; s < `RN_SLOTS; s++) begin
            b[s].valid = rnd_below(8) != 0;
            b[s].port = rnd_below(2);
            b[s].has_dest = rnd_below(4) != 0;
            b[s].rs1 = (rnd_below(8) == 0) ? 0 : $random(seed);
            b[s].rs2 = (rnd_below(8) == 0) ? 0 : $random(seed);
            b[s].dest = (rnd_below(8) == 0) ? 0 : $random(seed);
            b[s].op = $random(seed);
            fl_preg[s] = $random(seed);
            fl_empty[s] = rnd_below(12) == 0;
            commit[s].valid = (cycles > WARMUP) && (rnd_below(3) == 0);
            commit[s].arch = $random(seed);
            commit[s].preg = $random(seed);
        end
        // Make in-bundle dependences common
        if (rnd_below(4) == 0) b[1].rs1 = b[0].dest;
        if (rnd_below(4) == 0) b[1].rs2 = b[0].dest;
        if (rnd_below(6) == 0) b[1].dest = b[0].dest;
        bundle_in = b;
        valid_in = rnd_below(4) != 0;
        out_ready = rnd_below(5) != 0;
        recovery = (cycles > WARMUP) && (rnd_below(50) == 0);
    endtask

    // Sampled mid-cycle, predicts what the next rising edge does
    always @(negedge clk) begin : model_step
        logic       busy_m;
        logic       adv;
        logic [1:0] alloc_m;
        preg_t      cmt_next [`RN_ARCH_REGS];
        if (rst_n) begin
            busy_m = skid_m.size() == 2;
            alloc_m = '0;
            if (skid_m.size() > 0) begin
                alloc_m[0] = slot_allocates(skid_m[0][0]);
                alloc_m[1] = slot_allocates(skid_m[0][1]);
            end
            adv = (skid_m.size() > 0) && (!out_v_m || out_ready)
                  && !(|(alloc_m & fl_empty)) && !recovery;
            compare_word("busy", busy_m, busy);
            compare_word("out_valid", out_v_m, out_valid);
            compare_word("fl_pop", alloc_m & {2{adv}}, fl_pop);
            if (out_v_m && out_ready) begin
                compare_word("packet slot 0", pkt_m[0], out_pkt[0]);
                compare_word("packet slot 1", pkt_m[1], out_pkt[1]);
                delivered++;
            end
            cmt_next = cmt_m;
            for (int s = 0; s < `RN_SLOTS; s++) begin
                if (commit[s].valid) cmt_next[commit[s].arch] = commit[s].preg;
            end
            if (recovery) begin
                skid_m.delete();
                out_v_m = 1'b0;
                spec_m = cmt_next;
            end else begin
                if (adv) begin
                    rename_head(skid_m[0], fl_preg, pkt_m);
                    void'(skid_m.pop_front());
                    out_v_m = 1'b1;
                end else if (out_ready) begin
                    out_v_m = 1'b0;
                end
                if (valid_in && !busy_m) begin
                    skid_m.push_back(bundle_in);
                    accepted++;
                end
            end
            cmt_m = cmt_next;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Checks %0d, errors %0d, accepted %0d, delivered %0d",
                     checks, errors, accepted, delivered);
            $display("TB FAILED");
            $finish;
        end
    end

    initial begin
        rst_n = 1'b0;
        recovery = 1'b0;
        valid_in = 1'b0;
        bundle_in = '0;
        fl_preg = '0;
        fl_empty = '0;
        commit = '0;
        out_ready = 1'b0;
        out_v_m = 1'b0;
        pkt_m = '0;
        for (int i = 0; i < `RN_ARCH_REGS; i++) begin
            spec_m[i] = preg_t'(i);
            cmt_m[i] = preg_t'(i);
        end
        repeat (3) @(posedge clk);
        #1 rst_n = 1'b1;
        while (accepted < NUM_BUNDLES) begin
            drive_random();
            @(posedge clk);
            #1;
        end
        // Drain everything still in flight
        valid_in = 1'b0;
        fl_empty = '0;
        out_ready = 1'b1;
        recovery = 1'b0;
        commit = '0;
        while (skid_m.size() > 0 || out_v_m) begin
            @(posedge clk);
            #1;
        end
        $display("Checks %0d, errors %0d, accepted %0d, delivered %0d",
                 checks, errors, accepted, delivered);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+hdl
hdl/rename_pkg.sv
hdl/rename_skid.sv
hdl/rename_decode.sv
hdl/rename_map_table.sv
hdl/rename_result.sv
hdl/rename_top.sv
bench/tb_rename.sv

// ==== Bender.yml ====
package:
  name: rename

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/rename_pkg.sv
      - hdl/rename_skid.sv
      - hdl/rename_decode.sv
      - hdl/rename_map_table.sv
      - hdl/rename_result.sv
      - hdl/rename_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - bench/tb_rename.sv
